//--- verilog/icache_pkg.sv
package icache_pkg;

    ////////////////////
    // Geometry
    ////////////////////

    localparam int ADDR_WIDTH = 32;
    localparam int LINE_WIDTH = 128;
    localparam int NWAY = 4;
    localparam int NSET = 64;

    localparam int OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);
    localparam int INDEX_WIDTH = $clog2(NSET);
    localparam int WAY_WIDTH = $clog2(NWAY);
    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // Cache operation mode that clears every way of the set
    localparam logic [1:0] CACOP_ALL_WAYS = 2'd2;

    ////////////////////
    // Types
    ////////////////////

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [WAY_WIDTH-1:0] way_t;
    typedef logic [NWAY-1:0] way_mask_t;

    // Valid bit on top of the tag
    typedef logic [TAG_WIDTH:0] tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        FLUSH,
        REFILL_REQ,
        REFILL_WAIT,
        CACOP_WRITE,
        CACOP_DONE
    } cache_state_e;

endpackage

//--- verilog/sync_ram.sv
module sync_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     en_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    output logic [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read before write, output holds while disabled
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end
            rdata_o <= mem[addr_i];
        end
    end

endmodule

//--- verilog/lfsr16.sv
module lfsr16 (
    input  logic        clk,
    input  logic        rst,
    output logic [15:0] value_o
);

    localparam logic [15:0] SEED = 16'hace1;

    logic feedback;

    // Taps 16, 14, 13, 11 give the full 2^16-1 period
    assign feedback = value_o[15] ^ value_o[13] ^ value_o[12] ^ value_o[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            value_o <= SEED;
        end else begin
            value_o <= {value_o[14:0], feedback};
        end
    end

endmodule

//--- verilog/icache_lookup.sv
module icache_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  icache_pkg::addr_t      addr_i,
    input  logic                   uncached_i,
    input  logic                   accept_i,
    input  logic                   retire_i,
    input  logic                   ram_en_i,
    input  icache_pkg::index_t     ram_index_i,
    input  icache_pkg::way_mask_t  tag_we_i,
    input  icache_pkg::way_mask_t  data_we_i,
    input  icache_pkg::tag_entry_t tag_wdata_i,
    input  icache_pkg::line_t      line_wdata_i,
    output logic                   pending_o,
    output icache_pkg::addr_t      pend_addr_o,
    output logic                   pend_uncached_o,
    output logic                   hit_o,
    output icache_pkg::line_t      hit_line_o,
    output icache_pkg::way_t       victim_way_o
);

    import icache_pkg::*;

    tag_entry_t  tag_rdata [NWAY];
    line_t       data_rdata [NWAY];
    way_mask_t   way_hit;
    way_mask_t   way_valid;
    tag_t        pend_tag;
    logic [15:0] rand_value;

    ////////////////////
    // Request register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_o <= 1'b0;
        end else if (accept_i) begin
            pending_o <= 1'b1;
        end else if (retire_i) begin
            pending_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            pend_addr_o <= addr_i;
            pend_uncached_o <= uncached_i;
        end
    end

    assign pend_tag = pend_addr_o[ADDR_WIDTH-1 -: TAG_WIDTH];

    ////////////////////
    // Way RAMs
    ////////////////////

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        sync_ram #(
            .WIDTH(TAG_WIDTH + 1),
            .DEPTH(NSET)
        ) i_tag_ram (
            .clk    (clk),
            .en_i   (ram_en_i),
            .we_i   (tag_we_i[w]),
            .addr_i (ram_index_i),
            .wdata_i(tag_wdata_i),
            .rdata_o(tag_rdata[w])
        );

        sync_ram #(
            .WIDTH(LINE_WIDTH),
            .DEPTH(NSET)
        ) i_data_ram (
            .clk    (clk),
            .en_i   (ram_en_i),
            .we_i   (data_we_i[w]),
            .addr_i (ram_index_i),
            .wdata_i(line_wdata_i),
            .rdata_o(data_rdata[w])
        );

        assign way_valid[w] = tag_rdata[w][TAG_WIDTH];
        assign way_hit[w] = way_valid[w] && (tag_rdata[w][TAG_WIDTH-1:0] == pend_tag);
    end

    assign hit_o = |way_hit;

    always_comb begin
        hit_line_o = data_rdata[0];
        for (int w = 1; w < NWAY; w++) begin
            if (way_hit[w]) begin
                hit_line_o = data_rdata[w];
            end
        end
    end

    // Victim is the lowest invalid way, random when the set is full
    lfsr16 i_lfsr (
        .clk    (clk),
        .rst    (rst),
        .value_o(rand_value)
    );

    always_comb begin
        victim_way_o = rand_value[WAY_WIDTH-1:0];
        for (int w = NWAY - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                victim_way_o = way_t'(w);
            end
        end
    end

endmodule

//--- verilog/icache_ctrl.sv
module icache_ctrl (
    input  logic                   clk,
    input  logic                   rst,

    // Read port
    input  logic                   req_i,
    input  icache_pkg::addr_t      addr_i,
    output logic                   ack_o,
    output logic                   rvalid_o,
    output icache_pkg::line_t      rdata_o,

    // Control
    input  logic                   flush_i,
    input  logic                   cacop_i,
    input  logic [1:0]             cacop_mode_i,
    input  icache_pkg::addr_t      cacop_addr_i,
    output logic                   cacop_ack_o,

    // Line memory
    output logic                   mem_req_o,
    output icache_pkg::addr_t      mem_addr_o,
    input  logic                   mem_valid_i,
    input  icache_pkg::line_t      mem_line_i,

    // To lookup
    output logic                   accept_o,
    output logic                   retire_o,
    output logic                   ram_en_o,
    output icache_pkg::index_t     ram_index_o,
    output icache_pkg::way_mask_t  tag_we_o,
    output icache_pkg::way_mask_t  data_we_o,
    output icache_pkg::tag_entry_t tag_wdata_o,

    // From lookup
    input  logic                   pending_i,
    input  logic                   hit_i,
    input  icache_pkg::line_t      hit_line_i,
    input  icache_pkg::addr_t      pend_addr_i,
    input  logic                   pend_uncached_i,
    input  icache_pkg::way_t       victim_way_i
);

    import icache_pkg::*;

    cache_state_e state;
    cache_state_e state_next;

    logic      flush_pend;
    index_t    sweep_cnt;
    logic      miss;
    logic      start_flush;
    logic      refill_done;
    logic      refill_write;
    index_t    pend_index;
    index_t    cacop_index;
    way_mask_t victim_mask;
    way_mask_t cacop_mask;

    assign pend_index = pend_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
    assign cacop_index = cacop_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];

    ////////////////////
    // FSM
    ////////////////////

    // A lookup that found nothing
    assign miss = (state == IDLE) && pending_i && !hit_i;
    assign start_flush = (state == IDLE) && !miss && flush_pend;
    assign refill_done = (state == REFILL_WAIT) && mem_valid_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FLUSH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    state_next = REFILL_REQ;
                end else if (flush_pend) begin
                    state_next = FLUSH;
                end else if (cacop_i) begin
                    state_next = CACOP_WRITE;
                end
            end
            FLUSH: begin
                if (sweep_cnt == index_t'(NSET - 1)) begin
                    state_next = IDLE;
                end
            end
            REFILL_REQ: state_next = REFILL_WAIT;
            REFILL_WAIT: begin
                if (mem_valid_i) begin
                    state_next = IDLE;
                end
            end
            CACOP_WRITE: state_next = CACOP_DONE;
            CACOP_DONE: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // Flush waits here until the controller is free
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_pend <= 1'b0;
        end else if (flush_i) begin
            flush_pend <= 1'b1;
        end else if (start_flush) begin
            flush_pend <= 1'b0;
        end
    end

    // Wraps back to zero at the end of the sweep
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_cnt <= '0;
        end else if (state == FLUSH) begin
            sweep_cnt <= sweep_cnt + 1'b1;
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    assign ack_o = (state == IDLE) && !miss && !flush_pend && !cacop_i;
    assign accept_o = req_i && ack_o;

    assign rvalid_o = ((state == IDLE) && pending_i && hit_i) || refill_done;
    assign retire_o = rvalid_o;
    assign rdata_o = (state == REFILL_WAIT) ? mem_line_i : hit_line_i;

    assign mem_req_o = (state == REFILL_REQ);
    assign mem_addr_o = {pend_addr_i[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    assign cacop_ack_o = (state == CACOP_DONE);

    ////////////////////
    // RAM control
    ////////////////////

    // Uncached lines are never allocated
    assign refill_write = refill_done && !pend_uncached_i;
    assign victim_mask = way_mask_t'(1) << victim_way_i;
    assign cacop_mask = (cacop_mode_i == CACOP_ALL_WAYS) ? '1
                      : way_mask_t'(1) << cacop_addr_i[WAY_WIDTH-1:0];

    always_comb begin
        ram_en_o = 1'b0;
        ram_index_o = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
        tag_we_o = '0;
        data_we_o = '0;
        tag_wdata_o = '0;
        case (state)
            IDLE: ram_en_o = accept_o;
            FLUSH: begin
                ram_en_o = 1'b1;
                ram_index_o = sweep_cnt;
                tag_we_o = '1;
            end
            REFILL_REQ: ram_index_o = pend_index;
            REFILL_WAIT: begin
                ram_en_o = refill_write;
                ram_index_o = pend_index;
                tag_wdata_o = {1'b1, pend_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH]};
                if (refill_write) begin
                    tag_we_o = victim_mask;
                    data_we_o = victim_mask;
                end
            end
            CACOP_WRITE: begin
                ram_en_o = 1'b1;
                ram_index_o = cacop_index;
                tag_we_o = cacop_mask;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- verilog/icache_top.sv
module icache_top (
    input  logic               clk,
    input  logic               rst,

    // Read port
    input  logic               req_i,
    input  logic               uncached_i,
    input  icache_pkg::addr_t  addr_i,
    output logic               ack_o,
    output logic               rvalid_o,
    output icache_pkg::line_t  rdata_o,

    // Line memory
    output logic               mem_req_o,
    output icache_pkg::addr_t  mem_addr_o,
    input  logic               mem_valid_i,
    input  icache_pkg::line_t  mem_line_i,

    // Control
    input  logic               flush_i,
    input  logic               cacop_i,
    input  logic [1:0]         cacop_mode_i,
    input  icache_pkg::addr_t  cacop_addr_i,
    output logic               cacop_ack_o
);

    import icache_pkg::*;

    logic       accept;
    logic       retire;
    logic       ram_en;
    index_t     ram_index;
    way_mask_t  tag_we;
    way_mask_t  data_we;
    tag_entry_t tag_wdata;
    logic       pending;
    logic       hit;
    line_t      hit_line;
    addr_t      pend_addr;
    logic       pend_uncached;
    way_t       victim_way;

    icache_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req_i),
        .addr_i         (addr_i),
        .ack_o          (ack_o),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o),
        .flush_i        (flush_i),
        .cacop_i        (cacop_i),
        .cacop_mode_i   (cacop_mode_i),
        .cacop_addr_i   (cacop_addr_i),
        .cacop_ack_o    (cacop_ack_o),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_valid_i    (mem_valid_i),
        .mem_line_i     (mem_line_i),
        .accept_o       (accept),
        .retire_o       (retire),
        .ram_en_o       (ram_en),
        .ram_index_o    (ram_index),
        .tag_we_o       (tag_we),
        .data_we_o      (data_we),
        .tag_wdata_o    (tag_wdata),
        .pending_i      (pending),
        .hit_i          (hit),
        .hit_line_i     (hit_line),
        .pend_addr_i    (pend_addr),
        .pend_uncached_i(pend_uncached),
        .victim_way_i   (victim_way)
    );

    // Refill data comes straight from the memory response
    icache_lookup i_lookup (
        .clk            (clk),
        .rst            (rst),
        .addr_i         (addr_i),
        .uncached_i     (uncached_i),
        .accept_i       (accept),
        .retire_i       (retire),
        .ram_en_i       (ram_en),
        .ram_index_i    (ram_index),
        .tag_we_i       (tag_we),
        .data_we_i      (data_we),
        .tag_wdata_i    (tag_wdata),
        .line_wdata_i   (mem_line_i),
        .pending_o      (pending),
        .pend_addr_o    (pend_addr),
        .pend_uncached_o(pend_uncached),
        .hit_o          (hit),
        .hit_line_o     (hit_line),
        .victim_way_o   (victim_way)
    );

endmodule

//--- test/icache_asserts.sv
module icache_asserts (
    input logic clk,
    input logic rst,
    input logic req_i,
    input logic ack_o,
    input logic rvalid_o,
    input logic mem_req_o,
    input logic mem_valid_i
);

    logic resp_wait;
    logic read_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_wait <= 1'b0;
        end else if (mem_req_o) begin
            resp_wait <= 1'b1;
        end else if (mem_valid_i) begin
            resp_wait <= 1'b0;
        end
    end

    // A hit may retire while the next request is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            read_pend <= 1'b0;
        end else if (req_i && ack_o) begin
            read_pend <= 1'b1;
        end else if (rvalid_o) begin
            read_pend <= 1'b0;
        end
    end

    mem_req_single: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |=> !mem_req_o)
        else $error("mem_req_o held for two cycles");

    mem_req_alone: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |-> !resp_wait)
        else $error("memory request while a response is outstanding");

    rvalid_pending: assert property (@(posedge clk) disable iff (rst)
        rvalid_o |-> read_pend)
        else $error("rvalid_o without an accepted request");

endmodule

bind icache_top icache_asserts i_asserts (
    .clk        (clk),
    .rst        (rst),
    .req_i      (req_i),
    .ack_o      (ack_o),
    .rvalid_o   (rvalid_o),
    .mem_req_o  (mem_req_o),
    .mem_valid_i(mem_valid_i)
);

//--- test/icache_tb.sv
module icache_tb;

    import icache_pkg::*;

    localparam int N_OPS = 40;
    localparam int MEM_LAT_MAX = 8;
    localparam int PRED_MISS = 0;
    localparam int PRED_HIT = 1;
    localparam int PRED_UNKNOWN = 2;

    logic       clk;
    logic       rst;
    logic       req_i;
    logic       uncached_i;
    addr_t      addr_i;
    logic       ack_o;
    logic       rvalid_o;
    line_t      rdata_o;
    logic       mem_req_o;
    addr_t      mem_addr_o;
    logic       mem_valid_i = 1'b0;
    line_t      mem_line_i = '0;
    logic       flush_i;
    logic       cacop_i;
    logic [1:0] cacop_mode_i;
    addr_t      cacop_addr_i;
    logic       cacop_ack_o;

    // Reference view of the tag RAMs
    tag_t ref_tag [NSET][NWAY];
    logic ref_valid [NSET][NWAY];
    logic ref_lost [NSET];

    int          cycle_cnt = 0;
    int          accept_cnt = 0;
    int          done_cnt = 0;
    int          mem_req_cnt = 0;
    int          err_cnt = 0;
    logic        pend_valid = 1'b0;
    logic        pend_req_seen;
    addr_t       pend_addr;
    int          pend_cycle;
    int          pend_pred;
    int          mem_wait = 0;
    addr_t       mem_addr_q;
    int          test_cnt = 0;
    int          test_fail = 0;
    int          test_err0;
    addr_t       seen [5];

    icache_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .uncached_i  (uncached_i),
        .addr_i      (addr_i),
        .ack_o       (ack_o),
        .rvalid_o    (rvalid_o),
        .rdata_o     (rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_valid_i (mem_valid_i),
        .mem_line_i  (mem_line_i),
        .flush_i     (flush_i),
        .cacop_i     (cacop_i),
        .cacop_mode_i(cacop_mode_i),
        .cacop_addr_i(cacop_addr_i),
        .cacop_ack_o (cacop_ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic line_t ref_line(addr_t line_addr);
        line_t line;
        for (int w = 0; w < LINE_WIDTH / 32; w++) begin
            line[w*32 +: 32] = line_addr ^ (32'(w) * 32'h01010101);
        end
        return line;
    endfunction

    function automatic addr_t line_of(addr_t a);
        return {a[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    endfunction

    function automatic addr_t make_addr(tag_t tag, index_t idx, logic [OFFSET_WIDTH-1:0] off);
        return {tag, idx, off};
    endfunction

    // Lowest free way gets the line and a full set goes random
    function automatic int predict_read(addr_t a, logic unc);
        tag_t   tag;
        index_t idx;
        int     free_way;
        logic   hit;
        tag = a[ADDR_WIDTH-1 -: TAG_WIDTH];
        idx = a[OFFSET_WIDTH +: INDEX_WIDTH];
        free_way = -1;
        hit = 1'b0;
        for (int w = NWAY - 1; w >= 0; w--) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                hit = 1'b1;
            end
            if (!ref_valid[idx][w]) begin
                free_way = w;
            end
        end
        if (ref_lost[idx]) begin
            return PRED_UNKNOWN;
        end else if (hit) begin
            return PRED_HIT;
        end
        if (!unc && free_way < 0) begin
            ref_lost[idx] = 1'b1;
        end else if (!unc) begin
            ref_valid[idx][free_way] = 1'b1;
            ref_tag[idx][free_way] = tag;
        end
        return PRED_MISS;
    endfunction

    task automatic clear_ref();
        for (int s = 0; s < NSET; s++) begin
            ref_lost[s] = 1'b0;
            for (int w = 0; w < NWAY; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
    endtask

    task automatic invalidate_ref(logic [1:0] mode, addr_t a);
        index_t idx;
        idx = a[OFFSET_WIDTH +: INDEX_WIDTH];
        for (int w = 0; w < NWAY; w++) begin
            if (mode == CACOP_ALL_WAYS || w == int'(a[WAY_WIDTH-1:0])) begin
                ref_valid[idx][w] = 1'b0;
            end
        end
        if (mode == CACOP_ALL_WAYS) begin
            ref_lost[idx] = 1'b0;
        end
    endtask

    ////////////////////
    // Memory model
    ////////////////////

    always @(negedge clk) begin
        mem_valid_i = 1'b0;
        if (mem_wait > 0) begin
            mem_wait--;
            if (mem_wait == 0) begin
                mem_valid_i = 1'b1;
                mem_line_i = ref_line(mem_addr_q);
            end
        end
        if (mem_req_o) begin
            mem_wait = int'($urandom_range(MEM_LAT_MAX, 1));
            mem_addr_q = mem_addr_o;
        end
    end

    ////////////////////
    // Compare
    ////////////////////

    always @(posedge clk) begin
        if (rst) begin
            clear_ref();
            pend_valid = 1'b0;
        end else begin
            cycle_cnt++;
            if (flush_i) begin
                clear_ref();
            end
            if (cacop_ack_o) begin
                invalidate_ref(cacop_mode_i, cacop_addr_i);
            end
            if (mem_req_o) begin
                mem_req_cnt++;
                if (!pend_valid) begin
                    $display("Memory request with no read pending at cycle %0d", cycle_cnt);
                    err_cnt++;
                end else begin
                    if (mem_addr_o !== line_of(pend_addr)) begin
                        $display("[FAIL] mem_addr_o: got %h, expected %h",
                                 mem_addr_o, line_of(pend_addr));
                        err_cnt++;
                    end
                    if (cycle_cnt != pend_cycle + 2 || pend_pred == PRED_HIT) begin
                        $display("Unexpected memory request for %h at cycle %0d",
                                 pend_addr, cycle_cnt);
                        err_cnt++;
                    end
                    pend_req_seen = 1'b1;
                end
            end
            if (rvalid_o) begin
                if (!pend_valid) begin
                    $display("Read response with no read pending at cycle %0d", cycle_cnt);
                    err_cnt++;
                end else begin
                    if (rdata_o !== ref_line(line_of(pend_addr))) begin
                        $display("[FAIL] rdata_o: got %h, expected %h",
                                 rdata_o, ref_line(line_of(pend_addr)));
                        err_cnt++;
                    end
                    if (pend_pred == PRED_HIT && cycle_cnt != pend_cycle + 1) begin
                        $display("Hit on %h did not answer one cycle after accept", pend_addr);
                        err_cnt++;
                    end
                    if (pend_pred == PRED_MISS && !pend_req_seen) begin
                        $display("Read of %h answered without the expected refill", pend_addr);
                        err_cnt++;
                    end
                end
                pend_valid = 1'b0;
                done_cnt++;
            end
            if (req_i && ack_o) begin
                pend_valid = 1'b1;
                pend_addr = addr_i;
                pend_cycle = cycle_cnt;
                pend_req_seen = 1'b0;
                pend_pred = predict_read(addr_i, uncached_i);
                accept_cnt++;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // Called on a falling edge; a negative count skips the request check
    task automatic read_line(addr_t a, logic unc, int exp_reqs);
        int acc0;
        int done0;
        int req0;
        acc0 = accept_cnt;
        done0 = done_cnt;
        req0 = mem_req_cnt;
        req_i = 1'b1;
        addr_i = a;
        uncached_i = unc;
        while (accept_cnt == acc0) @(negedge clk);
        req_i = 1'b0;
        while (done_cnt == done0) @(negedge clk);
        if (exp_reqs >= 0 && mem_req_cnt - req0 != exp_reqs) begin
            $display("[FAIL] mem_req_o count for %h: got %h, expected %h",
                     a, mem_req_cnt - req0, exp_reqs);
            err_cnt++;
        end
    endtask

    task automatic flush_cache();
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        while (!ack_o) @(negedge clk);
    endtask

    task automatic cache_op(logic [1:0] mode, addr_t a);
        int n;
        n = 0;
        cacop_mode_i = mode;
        cacop_addr_i = a;
        cacop_i = 1'b1;
        while (!cacop_ack_o) begin
            @(negedge clk);
            n++;
        end
        cacop_i = 1'b0;
        if (n != 2) begin
            $display("cacop_ack_o came %0d cycles after the operation, not 2", n);
            err_cnt++;
        end
    endtask

    task automatic open_test();
        test_err0 = err_cnt;
    endtask

    task automatic report_test(string name);
        test_cnt++;
        if (err_cnt != test_err0) begin
            test_fail++;
            $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err0);
        end else begin
            $display("Test %0d %s: ok", test_cnt, name);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic reset_state();
        int   n;
        logic quiet;
        open_test();
        if (ack_o || mem_req_o || rvalid_o || cacop_ack_o) begin
            $display("Outputs are not all low after reset");
            err_cnt++;
        end
        n = 0;
        quiet = 1'b1;
        while (!ack_o && n < NSET + 4) begin
            if (mem_req_o || rvalid_o || cacop_ack_o) begin
                quiet = 1'b0;
            end
            @(negedge clk);
            n++;
        end
        if (!quiet) begin
            $display("A request or response strobe fired during the tag sweep");
            err_cnt++;
        end
        if (!ack_o) begin
            $display("ack_o did not rise within %0d cycles of reset", NSET + 4);
            err_cnt++;
        end else if (n < NSET) begin
            $display("ack_o rose after %0d cycles, before the tag sweep could finish", n);
            err_cnt++;
        end
        report_test("reset sweep");
    endtask

    task automatic first_and_repeat_read();
        open_test();
        seen[0] = make_addr(22'h00abc, 6'd1, 4'h8);
        read_line(seen[0], 1'b0, 1);
        read_line(seen[0], 1'b0, 0);
        report_test("first and repeat read");
    endtask

    task automatic set_replacement();
        open_test();
        for (int i = 0; i < NWAY; i++) begin
            read_line(make_addr(tag_t'(22'h100 + i), 6'd5, 4'(i * 4)), 1'b0, 1);
        end
        for (int i = 0; i < NWAY; i++) begin
            read_line(make_addr(tag_t'(22'h100 + i), 6'd5, 4'h0), 1'b0, 0);
        end
        seen[1] = make_addr(22'h104, 6'd5, 4'hc);
        read_line(seen[1], 1'b0, 1);
        read_line(seen[1], 1'b0, 0);
        for (int i = 0; i < NWAY; i++) begin
            read_line(make_addr(tag_t'(22'h100 + i), 6'd5, 4'h4), 1'b0, -1);
        end
        report_test("set replacement");
    endtask

    task automatic uncached_reads();
        open_test();
        seen[2] = make_addr(22'h3f00f, 6'd9, 4'h0);
        for (int i = 0; i < 3; i++) begin
            read_line(seen[2], 1'b1, 1);
        end
        read_line(seen[2], 1'b0, 1);
        read_line(seen[2], 1'b0, 0);
        report_test("uncached reads");
    endtask

    task automatic way_invalidation();
        addr_t line_b;
        open_test();
        seen[3] = make_addr(22'h001, 6'd12, 4'h0);
        line_b = make_addr(22'h002, 6'd12, 4'h4);
        flush_cache();
        read_line(seen[3], 1'b0, 1);
        read_line(line_b, 1'b0, 1);
        cache_op(2'd0, make_addr(22'h0, 6'd12, 4'h1));
        read_line(seen[3], 1'b0, 0);
        read_line(line_b, 1'b0, 1);
        cache_op(CACOP_ALL_WAYS, make_addr(22'h0, 6'd12, 4'h0));
        read_line(seen[3], 1'b0, 1);
        read_line(line_b, 1'b0, 1);
        report_test("cache operations");
    endtask

    task automatic flush_clears();
        open_test();
        seen[4] = make_addr(22'h2aaaa, 6'd30, 4'h0);
        read_line(seen[4], 1'b0, 1);
        flush_cache();
        for (int i = 0; i < 5; i++) begin
            read_line(seen[i], 1'b0, 1);
        end
        report_test("flush");
    endtask

    initial begin
        void'($urandom(92387));
        rst = 1'b1;
        req_i = 1'b0;
        uncached_i = 1'b0;
        addr_i = '0;
        flush_i = 1'b0;
        cacop_i = 1'b0;
        cacop_mode_i = 2'd0;
        cacop_addr_i = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state();
        first_and_repeat_read();
        set_replacement();
        uncached_reads();
        way_invalidation();
        flush_clears();
        $display("Tests run: %0d, failed: %0d, errors: %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (N_OPS * 40 + 2 * NSET) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", N_OPS * 40 + 2 * NSET);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- icache.f
verilog/icache_pkg.sv
verilog/sync_ram.sv
verilog/lfsr16.sv
verilog/icache_lookup.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
test/icache_asserts.sv
test/icache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = icache_tb
FILELIST  = icache.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
